// File: verilog/qla_defs.svh
`ifndef QLA_DEFS_SVH
`define QLA_DEFS_SVH

// ------------------------------
// Board layout
// ------------------------------
`define NUM_CHAN        4           // Motor channels on the QLA

// Host bus address fields
`define ADDR_MAIN       4'h0        // Main space in addr[15:12]
`define OFF_AMP_CTRL    4'h0        // Amp enable, data bit 0
`define OFF_DAC_CTRL    4'h1        // Commanded current

// ------------------------------
// Quad DAC
// ------------------------------
`define CUR_W           16          // Current command width
`define DAC_FRAME_W     24          // cmd + addr + data
`define DAC_CMD_WRUPD   4'b0011     // Write and update channel
`define DAC_HALF_DIV    4           // sysclk cycles per half sclk

`endif

// File: verilog/qla_pkg.sv
`default_nettype none

package qla_pkg;

`include "qla_defs.svh"

    // One commanded motor current
    typedef logic [`CUR_W-1:0] cur_cmd_t;

    // Channel register offsets in addr[3:0]
    typedef enum logic [3:0] {
        OFF_AMP = `OFF_AMP_CTRL,    // Amplifier enable
        OFF_DAC = `OFF_DAC_CTRL     // Current command
    } chan_off_t;

    // DAC serializer states
    typedef enum logic [1:0] {
        IDLE,       // Waiting for update
        SELECT,     // Load frame, drop csel
        SHIFT,      // Clock out 24 bits
        DESELECT    // csel high gap between frames
    } dac_state_t;

endpackage

`default_nettype wire

// File: verilog/reg_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

// One decoded channel register write
interface reg_wr_if import qla_pkg::*; ();

    logic                         wr_valid;   // Single-cycle write pulse
    logic [$clog2(`NUM_CHAN)-1:0] chan;       // Zero-based channel index
    chan_off_t                    offset;     // Register within channel
    logic [31:0]                  data;       // Host write data
    logic                         blk;        // Registered blk_wen

    // Decode side
    modport src (output wr_valid, chan, offset, data, blk);

    // Register side
    modport dst (input wr_valid, chan, offset, data, blk);

endinterface

`default_nettype wire

// File: verilog/dac_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

// Current commands and handshake toward the DAC serializer
interface dac_cmd_if import qla_pkg::*; ();

    cur_cmd_t cmd [`NUM_CHAN];  // Live commands, channel 1 at index 0
    logic     update;           // Pulse, DAC copies cmd on this cycle
    logic     busy;             // High while a burst is running

    // Register block side
    modport ctrl (output cmd, update, input busy);

    // Serializer side
    modport dac (input cmd, update, output busy);

endinterface

`default_nettype wire

// File: verilog/qla_write_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

module qla_write_decode import qla_pkg::*; (
    input  logic        sysclk,
    input  logic        rst_n,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    input  logic        blk_wen,
    reg_wr_if.src       wr
);

    localparam int IDX_W = $clog2(`NUM_CHAN);

    logic [3:0] space;      // addr[15:12]
    logic [3:0] chan_num;   // addr[7:4], one-based
    logic [3:0] off_raw;    // addr[3:0]
    logic       chan_ok;
    logic       off_ok;
    logic       hit;        // Write lands on a channel register

    assign space    = reg_waddr[15:12];
    assign chan_num = reg_waddr[7:4];
    assign off_raw  = reg_waddr[3:0];

    // Channel 0 holds board registers, not a motor
    assign chan_ok = (chan_num != 4'd0) && (chan_num <= 4'(`NUM_CHAN));

    always_comb begin
        case (off_raw)
            OFF_AMP, OFF_DAC: off_ok = 1'b1;
            default:          off_ok = 1'b0;   // Offsets outside this path
        endcase
    end

    assign hit = reg_wen && (space == `ADDR_MAIN) && chan_ok && off_ok;

    // Strobe, one cycle behind the host
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wr.wr_valid <= 1'b0;
        end else begin
            wr.wr_valid <= hit;
        end
    end

    // Write payload, held until the next accepted write
    always_ff @(posedge sysclk) begin
        if (hit) begin
            wr.chan   <= IDX_W'(chan_num - 4'd1);  // 1..4 -> 0..3
            wr.offset <= chan_off_t'(off_raw);
            wr.data   <= reg_wdata;
            wr.blk    <= blk_wen;
        end
    end

endmodule

`default_nettype wire

// File: verilog/qla_motor_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

module qla_motor_regs import qla_pkg::*; (
    input  logic                 sysclk,
    input  logic                 rst_n,
    reg_wr_if.dst                wr,
    dac_cmd_if.ctrl              dac,
    input  logic [15:0]          reg_raddr,
    output logic [31:0]          reg_rdata,
    output logic [`NUM_CHAN-1:0] amp_disable_pin
);

    localparam int IDX_W = $clog2(`NUM_CHAN);

    cur_cmd_t             cur_cmd [`NUM_CHAN];  // Commanded current per axis
    logic [`NUM_CHAN-1:0] amp_en;               // 1 -> amplifier on
    logic                 dac_req;              // Burst wanted
    logic                 serve;                // Request taken this cycle

    // ------------------------------
    // Channel registers
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_CHAN; i++) begin
                cur_cmd[i] <= '0;
            end
            amp_en <= '0;                           // All amps off
        end else if (wr.wr_valid) begin
            case (wr.offset)
                OFF_DAC: cur_cmd[wr.chan] <= wr.data[`CUR_W-1:0];
                OFF_AMP: amp_en[wr.chan]  <= wr.data[0];
                default: ;
            endcase
        end
    end

    assign amp_disable_pin = ~amp_en;   // Pin is active-high disable

    // ------------------------------
    // DAC update request
    // ------------------------------
    assign serve = dac_req && !dac.busy;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_req <= 1'b0;
        end else if (wr.wr_valid && wr.blk && (wr.offset == OFF_DAC)) begin
            dac_req <= 1'b1;    // Arm, or stay armed over a serve
        end else if (serve) begin
            dac_req <= 1'b0;
        end
    end

    // Pending writes collapse into one burst
    assign dac.update = serve;
    assign dac.cmd    = cur_cmd;

    // ------------------------------
    // Read-back mux
    // ------------------------------
    always_comb begin
        logic [3:0]       rd_chan;
        logic [IDX_W-1:0] rd_idx;

        rd_chan   = reg_raddr[7:4];
        rd_idx    = IDX_W'(rd_chan - 4'd1);
        reg_rdata = 32'd0;                      // Unknown addresses read 0
        if ((reg_raddr[15:12] == `ADDR_MAIN) && (rd_chan != 4'd0) &&
            (rd_chan <= 4'(`NUM_CHAN))) begin
            case (reg_raddr[3:0])
                OFF_DAC: reg_rdata = {{(32-`CUR_W){1'b0}}, cur_cmd[rd_idx]};
                OFF_AMP: reg_rdata = {31'd0, amp_en[rd_idx]};
                default: reg_rdata = 32'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/qla_dac_spi.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

module qla_dac_spi import qla_pkg::*; (
    input  logic    sysclk,
    input  logic    rst_n,
    dac_cmd_if.dac  dac,
    output logic    dac_sclk,
    output logic    dac_mosi,
    output logic    dac_csel
);

    localparam int IDX_W = $clog2(`NUM_CHAN);
    localparam int BIT_W = $clog2(`DAC_FRAME_W);
    localparam int DIV_W = $clog2(`DAC_HALF_DIV + 1);

    dac_state_t              state;
    logic [DIV_W-1:0]        div_cnt;       // Half-period divider
    logic                    tick;          // End of a half sclk period
    logic [BIT_W-1:0]        bit_cnt;       // Bit in frame, or gap count
    logic [IDX_W-1:0]        chan_idx;      // Frame being sent
    logic [`DAC_FRAME_W-1:0] shreg;         // Output shifter, MSB first
    cur_cmd_t                cmd_q [`NUM_CHAN];  // Snapshot taken on update

    assign tick = (div_cnt == DIV_W'(`DAC_HALF_DIV - 1));

    // Snapshot keeps the burst steady while the host writes new values
    always_ff @(posedge sysclk) begin
        if (dac.update) begin
            cmd_q <= dac.cmd;
        end
    end

    // ------------------------------
    // Serializer FSM
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            chan_idx <= '0;
            shreg    <= '0;
            dac_sclk <= 1'b0;
            dac_csel <= 1'b1;
        end else begin
            div_cnt <= (state == IDLE || tick) ? '0 : div_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (dac.update) begin
                        chan_idx <= '0;             // Channel 1 first
                        state    <= SELECT;
                    end
                end
                SELECT: if (tick) begin
                    // Frame: command, address nibble, 16 data bits
                    shreg    <= {`DAC_CMD_WRUPD, 4'(chan_idx), cmd_q[chan_idx]};
                    bit_cnt  <= '0;
                    dac_csel <= 1'b0;
                    state    <= SHIFT;
                end
                SHIFT: if (tick) begin
                    if (!dac_sclk) begin
                        dac_sclk <= 1'b1;           // DAC samples here
                    end else begin
                        dac_sclk <= 1'b0;
                        shreg    <= shreg << 1;     // Next bit while sclk low
                        if (bit_cnt == BIT_W'(`DAC_FRAME_W - 1)) begin
                            dac_csel <= 1'b1;       // Frame done
                            bit_cnt  <= '0;
                            state    <= DESELECT;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DESELECT: if (tick) begin
                    // Two half periods of csel high
                    if (bit_cnt == BIT_W'(1)) begin
                        if (chan_idx == IDX_W'(`NUM_CHAN - 1)) begin
                            state <= IDLE;          // Burst finished
                        end else begin
                            chan_idx <= chan_idx + 1'b1;
                            state    <= SELECT;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign dac_mosi = shreg[`DAC_FRAME_W-1];
    assign dac.busy = (state != IDLE);  // Rises the cycle after update

endmodule

`default_nettype wire

// File: verilog/qla_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

module qla_top import qla_pkg::*; (
    input  logic                 sysclk,
    input  logic                 rst_n,
    // Host bus
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic                 reg_wen,
    input  logic                 blk_wen,
    input  logic [15:0]          reg_raddr,
    output logic [31:0]          reg_rdata,
    // Quad DAC pins
    output logic                 dac_sclk,
    output logic                 dac_mosi,
    output logic                 dac_csel,
    // Amplifier disables, axis 1 in bit 0
    output logic [`NUM_CHAN-1:0] amp_disable_pin
);

    reg_wr_if  wr_bus ();   // Decode to registers
    dac_cmd_if dac_bus ();  // Registers to serializer

    // ------------------------------
    // Write path
    // ------------------------------
    qla_write_decode u_decode (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .blk_wen   (blk_wen),
        .wr        (wr_bus.src)
    );

    qla_motor_regs u_regs (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .wr              (wr_bus.dst),
        .dac             (dac_bus.ctrl),
        .reg_raddr       (reg_raddr),
        .reg_rdata       (reg_rdata),
        .amp_disable_pin (amp_disable_pin)
    );

    // ------------------------------
    // DAC output
    // ------------------------------
    qla_dac_spi u_dac (
        .sysclk   (sysclk),
        .rst_n    (rst_n),
        .dac      (dac_bus.dac),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi),
        .dac_csel (dac_csel)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

// sysclk at 50 MHz, reset held for the first 10 cycles
module tb_clock (
    output logic sysclk,
    output logic rst_n
);

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;   // 20 ns period
    end

    initial begin
        rst_n <= 1'b0;
        repeat (10) @(posedge sysclk);
        rst_n <= 1'b1;                  // Release on a rising edge
    end

endmodule

`default_nettype wire

// File: sim/tb_qla.sv
`timescale 1ns/100ps
`default_nettype none

`include "qla_defs.svh"

module tb_qla;

    logic        sysclk;
    logic        rst_n;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic        blk_wen;
    logic [15:0] reg_raddr;
    logic [31:0] reg_rdata;
    logic        dac_sclk;
    logic        dac_mosi;
    logic        dac_csel;
    logic [3:0]  amp_disable_pin;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr = 32'h5bb4;   // Galois LFSR state
    logic [15:0] cur [4];           // Expected commands with channel 1 at index 0
    logic [3:0]  amp_en;            // Expected enables
    logic [23:0] frames [$];        // Frames captured from the DAC pins
    logic [23:0] mon_sr;
    int          mon_cnt = 0;

    tb_clock u_clock (.sysclk(sysclk), .rst_n(rst_n));

    qla_top dut (
        .sysclk          (sysclk),
        .rst_n           (rst_n),
        .reg_waddr       (reg_waddr),
        .reg_wdata       (reg_wdata),
        .reg_wen         (reg_wen),
        .blk_wen         (blk_wen),
        .reg_raddr       (reg_raddr),
        .reg_rdata       (reg_rdata),
        .dac_sclk        (dac_sclk),
        .dac_mosi        (dac_mosi),
        .dac_csel        (dac_csel),
        .amp_disable_pin (amp_disable_pin)
    );

    // ------------------------------
    // DAC pin monitor
    // ------------------------------
    always @(posedge dac_sclk or posedge dac_csel) begin
        if (dac_csel) begin
            assert (mon_cnt == 0) else begin
                errors++;
                $display("DAC frame cut short after %0d bits at %0t", mon_cnt, $time);
            end
            mon_cnt = 0;
        end else begin
            mon_sr = {mon_sr[22:0], dac_mosi};  // MSB first
            mon_cnt++;
            if (mon_cnt == `DAC_FRAME_W) begin
                frames.push_back(mon_sr);
                mon_cnt = 0;
            end
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] chan_addr(logic [3:0] space, logic [3:0] ch, logic [3:0] off);
        return {space, 4'h0, ch, off};
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // Single-cycle host strobe
    task automatic host_write(logic [15:0] addr, logic [31:0] data, logic blk);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        blk_wen   <= blk;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
        blk_wen   <= 1'b0;
    endtask

    task automatic read_check(logic [15:0] addr, logic [31:0] exp, string name);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);                  // Read mux settled
        check_val(name, exp, reg_rdata);
    endtask

    task automatic check_all_regs();
        for (int ch = 1; ch <= 4; ch++) begin
            read_check(chan_addr(`ADDR_MAIN, 4'(ch), `OFF_DAC_CTRL), 32'(cur[ch-1]),
                       $sformatf("reg_rdata dac ch%0d", ch));
            read_check(chan_addr(`ADDR_MAIN, 4'(ch), `OFF_AMP_CTRL), 32'(amp_en[ch-1]),
                       $sformatf("reg_rdata amp ch%0d", ch));
        end
    endtask

    // Until n frames are in and csel is back high
    task automatic wait_frames(int n);
        int cnt;
        cnt = 0;
        while ((frames.size() < n || !dac_csel) && cnt < n * 1500) begin
            @(negedge sysclk);
            cnt++;
        end
        assert (cnt < n * 1500) else begin
            errors++;
            $display("Timed out waiting for %0d DAC frames, saw %0d", n, frames.size());
        end
    endtask

    task automatic wait_csel_low();
        int cnt;
        cnt = 0;
        while (dac_csel && cnt < 200) begin
            @(negedge sysclk);
            cnt++;
        end
        assert (!dac_csel) else begin
            errors++;
            $display("Timed out waiting for the DAC burst to start");
        end
    endtask

    // csel has to stay high over the whole window
    task automatic check_csel_quiet(int cycles, string name);
        int cnt;
        cnt = 0;
        while (dac_csel && cnt < cycles) begin
            @(negedge sysclk);
            cnt++;
        end
        check_val(name, 32'd1, 32'(dac_csel));
    endtask

    // Four frames for channels 1 to 4 in order
    task automatic check_burst(logic [15:0] exp_cmd [4]);
        logic [23:0] frame;
        for (int i = 0; i < 4; i++) begin
            frame = 'x;
            if (frames.size() > 0) begin
                frame = frames.pop_front();
            end
            check_val($sformatf("dac frame ch%0d", i + 1),
                      32'({`DAC_CMD_WRUPD, 4'(i), exp_cmd[i]}), 32'(frame));
        end
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        @(negedge sysclk);
        check_val("amp_disable_pin", 32'hf, 32'(amp_disable_pin));
        check_val("dac_csel", 32'd1, 32'(dac_csel));
        check_val("dac_sclk", 32'd0, 32'(dac_sclk));
        check_all_regs();   // Model is all zero here
    endtask

    task automatic test_cmd_write();
        logic [15:0] hi;
        for (int ch = 1; ch <= 4; ch++) begin
            cur[ch-1] = rand_bits(16);
            hi        = rand_bits(16);      // Dropped by the 16-bit register
            host_write(chan_addr(`ADDR_MAIN, 4'(ch), `OFF_DAC_CTRL), {hi, cur[ch-1]}, 1'b0);
        end
        check_all_regs();
        // Channel 0, channel 5 and another space are ignored
        host_write(chan_addr(`ADDR_MAIN, 4'd0, `OFF_DAC_CTRL), 32'h0000_1234, 1'b0);
        host_write(chan_addr(`ADDR_MAIN, 4'd5, `OFF_DAC_CTRL), 32'h0000_5678, 1'b0);
        host_write(chan_addr(4'h1, 4'd1, `OFF_DAC_CTRL), 32'h0000_9abc, 1'b0);
        check_all_regs();
        read_check(chan_addr(`ADDR_MAIN, 4'd5, `OFF_DAC_CTRL), 32'd0, "reg_rdata ch5");
    endtask

    task automatic test_amp();
        logic b;
        for (int round = 0; round < 2; round++) begin
            for (int ch = 1; ch <= 4; ch++) begin
                b = (round == 0) ? 1'(rand_bits(1)) : ~amp_en[ch-1];  // Second round flips
                amp_en[ch-1] = b;
                host_write(chan_addr(`ADDR_MAIN, 4'(ch), `OFF_AMP_CTRL),
                           {rand_bits(16), 15'd0, b}, 1'b0);
            end
            check_all_regs();
            check_val("amp_disable_pin", {28'd0, ~amp_en}, 32'(amp_disable_pin));
        end
    endtask

    task automatic test_dac_burst();
        frames.delete();
        for (int ch = 1; ch <= 4; ch++) begin
            cur[ch-1] = rand_bits(16);
            host_write(chan_addr(`ADDR_MAIN, 4'(ch), `OFF_DAC_CTRL), {16'd0, cur[ch-1]}, ch == 4);
        end
        wait_frames(4);
        check_csel_quiet(400, "dac_csel after burst");     // No stray fifth frame
        check_val("dac frame count", 32'd4, 32'(frames.size()));
        check_burst(cur);
        // Without blk_wen there is no burst
        cur[0] = rand_bits(16);
        host_write(chan_addr(`ADDR_MAIN, 4'd1, `OFF_DAC_CTRL), {16'd0, cur[0]}, 1'b0);
        check_csel_quiet(2000, "dac_csel");
    endtask

    task automatic test_backpressure();
        logic [15:0] first [4];
        frames.delete();
        cur[0] = rand_bits(16);
        host_write(chan_addr(`ADDR_MAIN, 4'd1, `OFF_DAC_CTRL), {16'd0, cur[0]}, 1'b1);
        first = cur;
        wait_csel_low();
        // New values and a second request pend behind the running burst
        for (int ch = 2; ch <= 4; ch++) begin
            cur[ch-1] = rand_bits(16);
            host_write(chan_addr(`ADDR_MAIN, 4'(ch), `OFF_DAC_CTRL), {16'd0, cur[ch-1]}, ch == 4);
        end
        wait_frames(8);
        check_val("dac frame count", 32'd8, 32'(frames.size()));
        check_burst(first);
        check_burst(cur);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int cnt;
        reg_waddr <= '0;
        reg_wdata <= '0;
        reg_wen   <= 1'b0;
        blk_wen   <= 1'b0;
        reg_raddr <= '0;
        cur    = '{default: '0};
        amp_en = '0;
        cnt    = 0;
        while (rst_n !== 1'b1 && cnt < 100) begin
            @(negedge sysclk);
            cnt++;
        end
        assert (rst_n === 1'b1) else begin
            errors++;
            $display("Reset was never released");
        end
        if (errors == 0) begin
            test_reset();
            test_cmd_write();
            test_amp();
            test_dac_burst();
            test_backpressure();
        end
        $display("Checks run: %0d, failures: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verilog
verilog/qla_pkg.sv
verilog/reg_wr_if.sv
verilog/dac_cmd_if.sv
verilog/qla_write_decode.sv
verilog/qla_motor_regs.sv
verilog/qla_dac_spi.sv
verilog/qla_top.sv
sim/tb_clock.sv
sim/tb_qla.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_qla
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
